//--- icache_pkg.sv
package icache_pkg;

    // fetch and memory widths
    localparam int unsigned addr_w = 32;
    localparam int unsigned inst_w = 32;
    localparam int unsigned pair_w = 64;

    // cache geometry
    localparam int unsigned way_num     = 2;
    localparam int unsigned set_num     = 128;
    localparam int unsigned block_bytes = 32;
    localparam int unsigned beat_num    = 8;

    // address fields
    localparam int unsigned index_lsb = 5;
    localparam int unsigned index_msb = 11;
    localparam int unsigned tag_lsb   = 12;
    localparam int unsigned pair_lsb  = 3;
    localparam int unsigned tag_w     = addr_w - tag_lsb;

    typedef logic [tag_w-1:0] tag_t;

    // one tag memory word
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // refill controller
    typedef enum logic [1:0] {
        s_normal,
        s_miss_req,
        s_miss_fill,
        s_done
    } ctrl_state_e;

endpackage

//--- icache_dpram.sv
`timescale 1ns/100ps

module icache_dpram #(
    parameter int unsigned width = 32,
    parameter int unsigned depth = 128
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     rd_en_i,
    input  logic [$clog2(depth)-1:0] rd_addr_i,
    output logic [width-1:0]         rd_data_o,
    input  logic                     wr_en_i,
    input  logic [$clog2(depth)-1:0] wr_addr_i,
    input  logic [width-1:0]         wr_data_i
);

    logic [width-1:0] mem_q [depth];

    // contents cleared so tag valid bits start low
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                mem_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            mem_q[wr_addr_i] <= wr_data_i;
        end
    end

    // read register keeps its value between reads
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem_q[rd_addr_i];
        end
    end

    // the controller only writes while lookups are stalled
    a_no_rw_same_addr: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rd_en_i && wr_en_i) |-> (rd_addr_i != wr_addr_i)
    );

endmodule

//--- icache_way.sv
`timescale 1ns/100ps

module icache_way #(
    parameter int unsigned set_num  = icache_pkg::set_num,
    parameter int unsigned beat_num = icache_pkg::beat_num
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          rd_en_i,
    input  logic [icache_pkg::addr_w-1:0] rd_addr_i,
    input  icache_pkg::tag_t              lookup_tag_i,
    input  logic                          data_we_i,
    input  logic [icache_pkg::addr_w-1:0] data_waddr_i,
    input  logic [icache_pkg::pair_w-1:0] data_wdata_i,
    input  logic                          tag_we_i,
    input  logic [icache_pkg::addr_w-1:0] tag_waddr_i,
    input  icache_pkg::tag_entry_t        tag_wdata_i,
    output logic                          hit_o,
    output logic [icache_pkg::pair_w-1:0] pair_o
);

    import icache_pkg::*;

    localparam int unsigned data_depth = set_num * beat_num * inst_w / pair_w;
    localparam int unsigned set_w      = $clog2(set_num);
    localparam int unsigned data_aw    = $clog2(data_depth);

    tag_entry_t         tag_rd;
    logic [set_w-1:0]   tag_raddr;
    logic [set_w-1:0]   tag_wa;
    logic [data_aw-1:0] data_raddr;
    logic [data_aw-1:0] data_wa;

    assign tag_raddr  = rd_addr_i[index_msb:index_lsb];
    assign tag_wa     = tag_waddr_i[index_msb:index_lsb];
    // pair address is index plus the pair position in the block
    assign data_raddr = rd_addr_i[index_msb:pair_lsb];
    assign data_wa    = data_waddr_i[index_msb:pair_lsb];

    icache_dpram #(
        .width($bits(tag_entry_t)),
        .depth(set_num)
    ) tag_mem_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_en_i  (rd_en_i),
        .rd_addr_i(tag_raddr),
        .rd_data_o(tag_rd),
        .wr_en_i  (tag_we_i),
        .wr_addr_i(tag_wa),
        .wr_data_i(tag_wdata_i)
    );

    icache_dpram #(
        .width(pair_w),
        .depth(data_depth)
    ) data_mem_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_en_i  (rd_en_i),
        .rd_addr_i(data_raddr),
        .rd_data_o(pair_o),
        .wr_en_i  (data_we_i),
        .wr_addr_i(data_wa),
        .wr_data_i(data_wdata_i)
    );

    assign hit_o = tag_rd.valid && (tag_rd.tag == lookup_tag_i);

endmodule

//--- icache_ctrl.sv
`timescale 1ns/100ps

module icache_ctrl #(
    parameter int unsigned way_num  = icache_pkg::way_num,
    parameter int unsigned set_num  = icache_pkg::set_num,
    parameter int unsigned beat_num = icache_pkg::beat_num
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          miss_i,
    input  logic [icache_pkg::addr_w-1:0] miss_pc_i,
    output logic                          mem_req_o,
    output logic [icache_pkg::addr_w-1:0] mem_addr_o,
    output logic [$clog2(beat_num):0]     mem_len_o,
    input  logic                          mem_req_ack_i,
    input  logic                          mem_data_valid_i,
    input  logic [icache_pkg::inst_w-1:0] mem_data_i,
    input  logic                          inval_valid_i,
    input  logic [icache_pkg::addr_w-1:0] inval_addr_i,
    output logic                          inval_ready_o,
    output logic                          inval_done_o,
    output logic                          busy_o,
    output logic                          refill_done_o,
    output logic [icache_pkg::pair_w-1:0] refill_insts_o,
    output logic [way_num-1:0]            data_we_o,
    output logic [icache_pkg::addr_w-1:0] data_waddr_o,
    output logic [icache_pkg::pair_w-1:0] data_wdata_o,
    output logic [way_num-1:0]            tag_we_o,
    output logic [icache_pkg::addr_w-1:0] tag_waddr_o,
    output icache_pkg::tag_entry_t        tag_wdata_o
);

    import icache_pkg::*;

    localparam int unsigned way_w = $clog2(way_num);
    localparam int unsigned cnt_w = $clog2(beat_num);
    localparam int unsigned set_w = $clog2(set_num);
    localparam logic [addr_w-1:0] block_mask = ~addr_w'(block_bytes - 1);

    ctrl_state_e        state_q;
    ctrl_state_e        state_d;
    logic [addr_w-1:0]  miss_pc_q;
    logic [way_w-1:0]   victim_q;
    logic [set_num-1:0] repl_q;
    logic [cnt_w-1:0]   beat_cnt_q;
    logic [inst_w-1:0]  low_beat_q;
    logic [pair_w-1:0]  refill_insts_q;
    logic               inval_done_q;
    logic               miss_start;
    logic               inval_fire;
    logic               beat_fire;
    logic               pair_fire;
    logic               last_beat;
    logic [set_w-1:0]   miss_set;
    logic [way_num-1:0] victim_oh;
    logic [way_num-1:0] inval_oh;

    assign miss_set   = miss_pc_q[index_msb:index_lsb];
    assign miss_start = (state_q == s_normal) && miss_i;

    // no maintenance while a miss is pending
    assign inval_ready_o = ((state_q == s_normal) || (state_q == s_done)) && !miss_i;
    assign inval_fire    = inval_valid_i && inval_ready_o;

    assign beat_fire = (state_q == s_miss_fill) && mem_data_valid_i;
    // odd beats complete a pair
    assign pair_fire = beat_fire && beat_cnt_q[0];
    assign last_beat = beat_fire && (beat_cnt_q == cnt_w'(beat_num - 1));

    assign victim_oh = way_num'(1) << victim_q;
    assign inval_oh  = way_num'(1) << inval_addr_i[way_w-1:0];

    always_comb begin
        state_d = state_q;
        case (state_q)
            s_normal: begin
                if (miss_i) begin
                    state_d = s_miss_req;
                end
            end
            s_miss_req: begin
                if (mem_req_ack_i) begin
                    state_d = s_miss_fill;
                end
            end
            s_miss_fill: begin
                if (last_beat) begin
                    state_d = s_done;
                end
            end
            s_done: begin
                state_d = s_normal;
            end
            default: begin
                state_d = s_normal;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q      <= s_normal;
            repl_q       <= '0;
            victim_q     <= '0;
            beat_cnt_q   <= '0;
            inval_done_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            inval_done_q <= inval_fire;
            if (miss_start) begin
                victim_q <= way_w'(repl_q[miss_pc_i[index_msb:index_lsb]]);
            end
            if (state_q == s_miss_req) begin
                beat_cnt_q <= '0;
            end else if (beat_fire) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
            end
            // next refill of this set goes to the other way
            if (last_beat) begin
                repl_q[miss_set] <= !repl_q[miss_set];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (miss_start) begin
            miss_pc_q <= miss_pc_i;
        end
        if (beat_fire && !beat_cnt_q[0]) begin
            low_beat_q <= mem_data_i;
        end
        // keep the pair that decode asked for
        if (pair_fire && (beat_cnt_q[cnt_w-1:1] == miss_pc_q[index_lsb-1:pair_lsb])) begin
            refill_insts_q <= {mem_data_i, low_beat_q};
        end
    end

    assign mem_req_o  = (state_q == s_miss_req);
    assign mem_addr_o = miss_pc_q & block_mask;
    assign mem_len_o  = ($clog2(beat_num) + 1)'(beat_num);

    assign busy_o = miss_i || (state_q == s_miss_req) || (state_q == s_miss_fill) ||
                    inval_fire;
    assign refill_done_o  = (state_q == s_done);
    assign refill_insts_o = refill_insts_q;
    assign inval_done_o   = inval_done_q;

    assign data_we_o    = pair_fire ? victim_oh : '0;
    assign data_waddr_o = {miss_pc_q[addr_w-1:index_lsb], beat_cnt_q[cnt_w-1:1],
                           {pair_lsb{1'b0}}};
    assign data_wdata_o = {mem_data_i, low_beat_q};

    // tag goes valid together with the last pair
    assign tag_we_o          = last_beat ? victim_oh : (inval_fire ? inval_oh : '0);
    assign tag_waddr_o       = last_beat ? miss_pc_q : inval_addr_i;
    assign tag_wdata_o.valid = last_beat;
    assign tag_wdata_o.tag   = last_beat ? miss_pc_q[addr_w-1:tag_lsb] : '0;

    a_req_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (mem_req_o && !mem_req_ack_i) |=> (mem_req_o && $stable(mem_addr_o))
    );

endmodule

//--- icache_lookup_stage.sv
`timescale 1ns/100ps

module icache_lookup_stage #(
    parameter int unsigned way_num = icache_pkg::way_num
) (
    input  logic                                       clk,
    input  logic                                       rst_n,
    input  logic                                       flush_i,
    input  logic                                       fetch_valid_i,
    input  logic [icache_pkg::addr_w-1:0]              fetch_pc_i,
    input  logic [1:0]                                 fetch_mask_i,
    output logic                                       fetch_ready_o,
    input  logic [way_num-1:0]                         way_hit_i,
    input  logic [way_num-1:0][icache_pkg::pair_w-1:0] way_pair_i,
    input  logic                                       busy_i,
    input  logic                                       refill_done_i,
    input  logic [icache_pkg::pair_w-1:0]              refill_insts_i,
    output logic                                       miss_o,
    output logic [icache_pkg::addr_w-1:0]              stage_pc_o,
    output logic                                       rd_en_o,
    output logic                                       inst_valid_o,
    output logic [icache_pkg::addr_w-1:0]              inst_pc_o,
    output logic [1:0]                                 inst_mask_o,
    output logic [icache_pkg::pair_w-1:0]              insts_o
);

    import icache_pkg::*;

    logic              valid_q;
    logic [addr_w-1:0] pc_q;
    logic [1:0]        mask_q;
    logic              any_hit;
    logic              mask_set;
    logic [pair_w-1:0] hit_pair;

    assign fetch_ready_o = !busy_i;
    // memories are read with the incoming pc
    assign rd_en_o = fetch_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            valid_q <= 1'b0;
        end else if (!busy_i) begin
            valid_q <= fetch_valid_i;
        end else if (inst_valid_o) begin
            // delivered during an invalidate stall, drop it
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid_i && fetch_ready_o) begin
            pc_q   <= fetch_pc_i;
            mask_q <= fetch_mask_i;
        end
    end

    always_comb begin
        hit_pair = '0;
        for (int w = 0; w < way_num; w++) begin
            if (way_hit_i[w]) begin
                hit_pair = way_pair_i[w];
            end
        end
    end

    assign any_hit  = |way_hit_i;
    // empty mask needs no data
    assign mask_set = |mask_q;

    assign miss_o       = valid_q && mask_set && !any_hit && !refill_done_i && !flush_i;
    assign inst_valid_o = valid_q && mask_set && (any_hit || refill_done_i) && !flush_i;
    assign insts_o      = refill_done_i ? refill_insts_i : hit_pair;
    assign inst_pc_o    = pc_q;
    assign inst_mask_o  = mask_q;
    assign stage_pc_o   = pc_q;

    // a block is filled into one way only
    a_single_way_hit: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_q |-> $onehot0(way_hit_i)
    );

endmodule

//--- icache_top.sv
`timescale 1ns/100ps

module icache_top #(
    parameter int unsigned way_num  = icache_pkg::way_num,
    parameter int unsigned set_num  = icache_pkg::set_num,
    parameter int unsigned beat_num = icache_pkg::beat_num
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          flush_i,
    input  logic                          fetch_valid_i,
    input  logic [icache_pkg::addr_w-1:0] fetch_pc_i,
    input  logic [1:0]                    fetch_mask_i,
    output logic                          fetch_ready_o,
    output logic                          inst_valid_o,
    output logic [icache_pkg::addr_w-1:0] inst_pc_o,
    output logic [1:0]                    inst_mask_o,
    output logic [icache_pkg::pair_w-1:0] insts_o,
    output logic                          mem_req_o,
    output logic [icache_pkg::addr_w-1:0] mem_addr_o,
    output logic [$clog2(beat_num):0]     mem_len_o,
    input  logic                          mem_req_ack_i,
    input  logic                          mem_data_valid_i,
    input  logic [icache_pkg::inst_w-1:0] mem_data_i,
    input  logic                          inval_valid_i,
    input  logic [icache_pkg::addr_w-1:0] inval_addr_i,
    output logic                          inval_ready_o,
    output logic                          inval_done_o
);

    import icache_pkg::*;

    logic                           miss;
    logic [addr_w-1:0]              stage_pc;
    logic                           rd_en;
    logic [way_num-1:0]             way_hit;
    logic [way_num-1:0][pair_w-1:0] way_pair;
    logic                           busy;
    logic                           refill_done;
    logic [pair_w-1:0]              refill_insts;
    logic [way_num-1:0]             data_we;
    logic [addr_w-1:0]              data_waddr;
    logic [pair_w-1:0]              data_wdata;
    logic [way_num-1:0]             tag_we;
    logic [addr_w-1:0]              tag_waddr;
    tag_entry_t                     tag_wdata;

    icache_lookup_stage #(
        .way_num(way_num)
    ) stage_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush_i),
        .fetch_valid_i (fetch_valid_i),
        .fetch_pc_i    (fetch_pc_i),
        .fetch_mask_i  (fetch_mask_i),
        .fetch_ready_o (fetch_ready_o),
        .way_hit_i     (way_hit),
        .way_pair_i    (way_pair),
        .busy_i        (busy),
        .refill_done_i (refill_done),
        .refill_insts_i(refill_insts),
        .miss_o        (miss),
        .stage_pc_o    (stage_pc),
        .rd_en_o       (rd_en),
        .inst_valid_o  (inst_valid_o),
        .inst_pc_o     (inst_pc_o),
        .inst_mask_o   (inst_mask_o),
        .insts_o       (insts_o)
    );

    for (genvar w = 0; w < way_num; w++) begin : g_way
        icache_way #(
            .set_num (set_num),
            .beat_num(beat_num)
        ) way_i (
            .clk         (clk),
            .rst_n       (rst_n),
            .rd_en_i     (rd_en),
            .rd_addr_i   (fetch_pc_i),
            .lookup_tag_i(stage_pc[addr_w-1:tag_lsb]),
            .data_we_i   (data_we[w]),
            .data_waddr_i(data_waddr),
            .data_wdata_i(data_wdata),
            .tag_we_i    (tag_we[w]),
            .tag_waddr_i (tag_waddr),
            .tag_wdata_i (tag_wdata),
            .hit_o       (way_hit[w]),
            .pair_o      (way_pair[w])
        );
    end

    icache_ctrl #(
        .way_num (way_num),
        .set_num (set_num),
        .beat_num(beat_num)
    ) ctrl_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .miss_i          (miss),
        .miss_pc_i       (stage_pc),
        .mem_req_o       (mem_req_o),
        .mem_addr_o      (mem_addr_o),
        .mem_len_o       (mem_len_o),
        .mem_req_ack_i   (mem_req_ack_i),
        .mem_data_valid_i(mem_data_valid_i),
        .mem_data_i      (mem_data_i),
        .inval_valid_i   (inval_valid_i),
        .inval_addr_i    (inval_addr_i),
        .inval_ready_o   (inval_ready_o),
        .inval_done_o    (inval_done_o),
        .busy_o          (busy),
        .refill_done_o   (refill_done),
        .refill_insts_o  (refill_insts),
        .data_we_o       (data_we),
        .data_waddr_o    (data_waddr),
        .data_wdata_o    (data_wdata),
        .tag_we_o        (tag_we),
        .tag_waddr_o     (tag_waddr),
        .tag_wdata_o     (tag_wdata)
    );

endmodule

//--- tb_mem_model.sv
`timescale 1ns/100ps

module tb_mem_model #(
    parameter logic [31:0] data_key = 32'h5a5a_c3c3
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mem_req_i,
    input  logic [31:0] mem_addr_i,
    input  logic [3:0]  mem_len_i,
    output logic        mem_req_ack_o,
    output logic        mem_data_valid_o,
    output logic [31:0] mem_data_o,
    output int          req_count_o,
    output logic [31:0] last_addr_o,
    output logic [3:0]  last_len_o
);

    integer      seed;
    int          delay;
    int          gap;
    int          len;
    logic [31:0] addr;

    initial begin
        seed             = 66;
        mem_req_ack_o    = 1'b0;
        mem_data_valid_o = 1'b0;
        mem_data_o       = '0;
        req_count_o      = 0;
        last_addr_o      = '0;
        last_len_o       = '0;
        forever begin
            @(negedge clk);
            if (rst_n && mem_req_i) begin
                addr        = mem_addr_i;
                len         = 32'(mem_len_i);
                last_addr_o <= mem_addr_i;
                last_len_o  <= mem_len_i;
                // ack after 0 to 3 idle cycles
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(posedge clk);
                @(posedge clk);
                mem_req_ack_o <= 1'b1;
                req_count_o   <= req_count_o + 1;
                @(posedge clk);
                mem_req_ack_o <= 1'b0;
                for (int i = 0; i < len; i++) begin
                    gap = $unsigned($random(seed)) % 3;
                    repeat (gap) begin
                        mem_data_valid_o <= 1'b0;
                        @(posedge clk);
                    end
                    // beat data is its byte address scrambled
                    mem_data_valid_o <= 1'b1;
                    mem_data_o       <= (addr + 32'(4 * i)) ^ data_key;
                    @(posedge clk);
                end
                mem_data_valid_o <= 1'b0;
            end
        end
    end

endmodule

//--- tb_icache.sv
`timescale 1ns/100ps

module tb_icache;

    import icache_pkg::*;

    localparam logic [31:0] data_key = 32'h5a5a_c3c3;
    localparam int          n_rows   = 16;
    localparam int          limit    = n_rows * 40;

    typedef struct packed {
        logic [31:0] pc;
        logic [1:0]  mask;
        logic        flush;
        logic        inval;
        logic        pair;
        logic [1:0]  reqs;
    } row_t;

    logic              clk;
    logic              rst_n;
    logic              flush;
    logic              fetch_valid;
    logic [addr_w-1:0] fetch_pc;
    logic [1:0]        fetch_mask;
    logic              fetch_ready;
    logic              inst_valid;
    logic [addr_w-1:0] inst_pc;
    logic [1:0]        inst_mask;
    logic [pair_w-1:0] insts;
    logic              mem_req;
    logic [addr_w-1:0] mem_addr;
    logic [3:0]        mem_len;
    logic              mem_ack;
    logic              mem_data_valid;
    logic [inst_w-1:0] mem_data;
    logic              inval_valid;
    logic [addr_w-1:0] inval_addr;
    logic              inval_ready;
    logic              inval_done;
    int                req_count;
    logic [31:0]       last_addr;
    logic [3:0]        last_len;

    row_t              rows [n_rows];
    logic [31:0]       out_pc [$];
    logic [1:0]        out_mask [$];
    logic [63:0]       out_insts [$];
    int                errors = 0;
    int                failed = 0;
    int                cycles = 0;

    icache_top icache_top_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush_i         (flush),
        .fetch_valid_i   (fetch_valid),
        .fetch_pc_i      (fetch_pc),
        .fetch_mask_i    (fetch_mask),
        .fetch_ready_o   (fetch_ready),
        .inst_valid_o    (inst_valid),
        .inst_pc_o       (inst_pc),
        .inst_mask_o     (inst_mask),
        .insts_o         (insts),
        .mem_req_o       (mem_req),
        .mem_addr_o      (mem_addr),
        .mem_len_o       (mem_len),
        .mem_req_ack_i   (mem_ack),
        .mem_data_valid_i(mem_data_valid),
        .mem_data_i      (mem_data),
        .inval_valid_i   (inval_valid),
        .inval_addr_i    (inval_addr),
        .inval_ready_o   (inval_ready),
        .inval_done_o    (inval_done)
    );

    tb_mem_model #(
        .data_key(data_key)
    ) mem_model_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_req_i       (mem_req),
        .mem_addr_i      (mem_addr),
        .mem_len_i       (mem_len),
        .mem_req_ack_o   (mem_ack),
        .mem_data_valid_o(mem_data_valid),
        .mem_data_o      (mem_data),
        .req_count_o     (req_count),
        .last_addr_o     (last_addr),
        .last_len_o      (last_len)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: the run did not finish within %0d cycles", limit);
            $display("Some tests failed");
            $finish;
        end
    end

    // decode side outputs, sampled mid cycle
    always @(negedge clk) begin
        if (rst_n && inst_valid) begin
            out_pc.push_back(inst_pc);
            out_mask.push_back(inst_mask);
            out_insts.push_back(insts);
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [63:0] expected_pair(input logic [31:0] pc);
        logic [31:0] base;
        base = pc & 32'hffff_fff8;
        return {(base + 32'd4) ^ data_key, base ^ data_key};
    endfunction

    function automatic int expected_outputs(input row_t row);
        if (row.inval || row.flush || row.mask == 2'b00) begin
            return 0;
        end
        return row.pair ? 2 : 1;
    endfunction

    task automatic load_rows();
        // pc or inval address, mask, flush, inval, second pc, memory requests
        rows[0]  = '{32'h0000_0100, 2'b11, 1'b0, 1'b0, 1'b0, 2'd1};
        rows[1]  = '{32'h0000_0108, 2'b11, 1'b0, 1'b0, 1'b0, 2'd0};
        rows[2]  = '{32'h0000_0110, 2'b11, 1'b0, 1'b0, 1'b1, 2'd0};
        rows[3]  = '{32'h0000_0110, 2'b01, 1'b0, 1'b0, 1'b0, 2'd0};
        rows[4]  = '{32'h0000_0118, 2'b10, 1'b0, 1'b0, 1'b0, 2'd0};
        rows[5]  = '{32'h0000_5000, 2'b00, 1'b0, 1'b0, 1'b0, 2'd0};
        // set 3 with tags 1, 2 and 3
        rows[6]  = '{32'h0000_1060, 2'b11, 1'b0, 1'b0, 1'b0, 2'd1};
        rows[7]  = '{32'h0000_2060, 2'b11, 1'b0, 1'b0, 1'b0, 2'd1};
        rows[8]  = '{32'h0000_1068, 2'b11, 1'b0, 1'b0, 1'b0, 2'd0};
        rows[9]  = '{32'h0000_3060, 2'b11, 1'b0, 1'b0, 1'b0, 2'd1};
        rows[10] = '{32'h0000_2068, 2'b11, 1'b0, 1'b0, 1'b0, 2'd0};
        rows[11] = '{32'h0000_1060, 2'b01, 1'b0, 1'b0, 1'b0, 2'd1};
        // set 8 way 0 holds block 0x100
        rows[12] = '{32'h0000_0100, 2'b00, 1'b0, 1'b1, 1'b0, 2'd0};
        rows[13] = '{32'h0000_0108, 2'b11, 1'b0, 1'b0, 1'b0, 2'd1};
        rows[14] = '{32'h0000_7200, 2'b11, 1'b1, 1'b0, 1'b0, 2'd1};
        rows[15] = '{32'h0000_7208, 2'b11, 1'b0, 1'b0, 1'b0, 2'd0};
    endtask

    task automatic issue_fetch(input row_t row);
        int waited;
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch_pc    <= row.pc;
        fetch_mask  <= row.mask;
        if (row.pair) begin
            @(posedge clk);
            fetch_pc <= row.pc + 32'd8;
        end
        @(posedge clk);
        fetch_valid <= 1'b0;
        if (row.flush) begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (!mem_req && waited < 40);
            // drop the fetch while its refill is running
            @(posedge clk);
            flush <= 1'b1;
            @(posedge clk);
            flush <= 1'b0;
        end
    endtask

    task automatic invalidate_way(input logic [31:0] addr);
        int waited;
        @(posedge clk);
        inval_valid <= 1'b1;
        inval_addr  <= addr;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!inval_ready && waited < 40);
        check_value("inval_ready_o", 64'(inval_ready), 64'd1);
        @(posedge clk);
        inval_valid <= 1'b0;
        @(negedge clk);
        check_value("inval_done_o", 64'(inval_done), 64'd1);
        @(negedge clk);
        check_value("inval_done_o", 64'(inval_done), 64'd0);
    endtask

    task automatic run_row(input int r);
        row_t row;
        int   req_before;
        int   err_before;
        int   n_out;
        int   waited;
        row        = rows[r];
        req_before = req_count;
        err_before = errors;
        n_out      = expected_outputs(row);
        out_pc.delete();
        out_mask.delete();
        out_insts.delete();
        if (row.inval) begin
            invalidate_way(row.pc);
        end else begin
            issue_fetch(row);
            waited = 0;
            while (out_pc.size() < n_out && waited < 40) begin
                @(negedge clk);
                waited++;
            end
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (!fetch_ready && waited < 40);
            @(negedge clk);
        end
        check_value("output count", 64'(out_pc.size()), 64'(n_out));
        for (int k = 0; k < out_pc.size() && k < n_out; k++) begin
            check_value("inst_pc_o", 64'(out_pc[k]), 64'(row.pc + 32'(8 * k)));
            check_value("inst_mask_o", 64'(out_mask[k]), 64'(row.mask));
            check_value("insts_o", out_insts[k], expected_pair(row.pc + 32'(8 * k)));
        end
        check_value("memory requests", 64'(req_count - req_before), 64'(row.reqs));
        if (row.reqs != 2'd0) begin
            check_value("mem_addr_o", 64'(last_addr), 64'(row.pc & 32'hffff_ffe0));
            check_value("mem_len_o", 64'(last_len), 64'd8);
        end
        if (errors != err_before) begin
            failed++;
        end
        $display("test %0d pc %h mask %b: %s", r, row.pc, row.mask,
                 (errors == err_before) ? "ok" : "failed");
    endtask

    initial begin
        rst_n       = 1'b0;
        flush       = 1'b0;
        fetch_valid = 1'b0;
        fetch_pc    = '0;
        fetch_mask  = '0;
        inval_valid = 1'b0;
        inval_addr  = '0;
        load_rows();
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("fetch_ready_o", 64'(fetch_ready), 64'd1);
        check_value("inst_valid_o", 64'(inst_valid), 64'd0);
        check_value("mem_req_o", 64'(mem_req), 64'd0);
        check_value("inval_done_o", 64'(inval_done), 64'd0);
        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end
        $display("%0d tests, %0d failed, %0d mismatches", n_rows, failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
icache_pkg.sv
icache_dpram.sv
icache_way.sv
icache_ctrl.sv
icache_lookup_stage.sv
icache_top.sv
tb_mem_model.sv
tb_icache.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_icache -f filelist.f \
    --Mdir obj_dir -o tb_icache_sim || exit 1
./obj_dir/tb_icache_sim | tee /dev/stderr | grep -q "All tests passed" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
